// File: filelist.f
source/isa_pkg.sv
source/pipe_pkg.sv
source/fetch_stage.sv
source/register_file.sv
source/decode_stage.sv
source/execute_stage.sv
source/memory_stage.sv
source/riscv_core.sv
test/core_tb.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
    --top-module core_tb -o core_tb_sim \
    && ./obj_dir/core_tb_sim | tee /dev/stderr | grep -q -F "All tests passed" \
    && echo "Simulation PASSED" \
    || { echo "Simulation FAILED"; exit 1; }

// File: source/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic              clk_50,
    input  logic              reset,
    input  pipe_pkg::if_id_t  if_id,
    input  pipe_pkg::mem_wb_t wb,
    input  logic              flush,
    input  logic              ex_mem_read,
    input  logic [4:0]        ex_rd,
    input  logic [4:0]        dbg_addr,
    output logic [31:0]       dbg_data,
    output logic              stall,
    output pipe_pkg::id_ex_t  id_ex
);

    isa_pkg::inst_u     inst;
    pipe_pkg::ctrl_t    ctrl;
    logic [1:0]         alu_op;
    isa_pkg::alu_ctrl_t alu_ctrl;
    logic               npu_en;
    logic [31:0]        imm;
    logic [31:0]        rs1_val;
    logic [31:0]        rs2_val;
    logic               bubble;

    assign inst = if_id.inst;

    // Load in execute feeding this instruction
    assign stall = if_id.valid && ex_mem_read && ex_rd != 5'd0 &&
                   (ex_rd == inst.r.rs1 || ex_rd == inst.r.rs2);

    assign bubble = flush || stall || !if_id.valid;

    register_file u_register_file (
        .clk_50   (clk_50),
        .reset    (reset),
        .rr1      (inst.r.rs1),
        .rr2      (inst.r.rs2),
        .wb       (wb),
        .rd1      (rs1_val),
        .rd2      (rs2_val),
        .dbg_addr (dbg_addr),
        .dbg_data (dbg_data)
    );

    // ALUOp: 00 add, 01 sub, 10 by funct, 11 npu
    always_comb begin
        ctrl   = '0;
        alu_op = 2'b00;
        case (inst.r.opcode)
            isa_pkg::op_rtype: begin
                ctrl.reg_write = 1'b1;
                alu_op         = 2'b10;
            end
            isa_pkg::op_itype: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                alu_op         = 2'b10;
            end
            isa_pkg::op_load: begin
                ctrl.reg_write  = 1'b1;
                ctrl.mem_read   = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.alu_src    = 1'b1;
            end
            isa_pkg::op_store: begin
                ctrl.mem_write = 1'b1;
                ctrl.alu_src   = 1'b1;
            end
            isa_pkg::op_branch: begin
                ctrl.branch = 1'b1;
                alu_op      = 2'b01;
            end
            isa_pkg::op_npu: begin
                ctrl.reg_write = 1'b1;
                alu_op         = 2'b11;
            end
            default: ;
        endcase
    end

    always_comb begin
        case (inst.r.opcode)
            isa_pkg::op_store:
                imm = {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
            isa_pkg::op_branch:
                imm = {{19{inst.b.imm_12}}, inst.b.imm_12, inst.b.imm_11,
                       inst.b.imm_10_5, inst.b.imm_4_1, 1'b0};
            default:
                imm = {{20{inst.i.imm[11]}}, inst.i.imm};
        endcase
    end

    always_comb begin
        alu_ctrl = isa_pkg::alu_add;
        case (alu_op)
            2'b01: alu_ctrl = isa_pkg::alu_sub;
            2'b11: alu_ctrl = isa_pkg::alu_npu;
            2'b10: begin
                case (inst.r.funct3)
                    isa_pkg::f3_add_sub: begin
                        // funct7 is immediate bits for addi
                        if (!ctrl.alu_src && inst.r.funct7 == isa_pkg::f7_sub) begin
                            alu_ctrl = isa_pkg::alu_sub;
                        end
                    end
                    isa_pkg::f3_slt: alu_ctrl = isa_pkg::alu_slt;
                    isa_pkg::f3_or:  alu_ctrl = isa_pkg::alu_or;
                    isa_pkg::f3_and: alu_ctrl = isa_pkg::alu_and;
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

    assign npu_en = (alu_ctrl == isa_pkg::alu_npu);

    always_ff @(posedge clk_50) begin
        if (reset || bubble) begin
            id_ex.ctrl   <= '0;
            id_ex.npu_en <= 1'b0;
        end else begin
            id_ex.ctrl   <= ctrl;
            id_ex.npu_en <= npu_en;
        end
        id_ex.alu_ctrl <= alu_ctrl;
        id_ex.pc       <= if_id.pc;
        id_ex.rs1_val  <= rs1_val;
        id_ex.rs2_val  <= rs2_val;
        id_ex.imm      <= imm;
        id_ex.rs1      <= inst.r.rs1;
        id_ex.rs2      <= inst.r.rs2;
        id_ex.rd       <= inst.r.rd;
    end

endmodule

// File: source/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic              clk_50,
    input  logic              reset,
    input  pipe_pkg::id_ex_t  id_ex,
    input  pipe_pkg::fwd_t    fwd_wb,
    output pipe_pkg::ex_mem_t ex_mem,
    output pipe_pkg::fwd_t    fwd_mem,
    output logic              ex_mem_read,
    output logic [4:0]        ex_rd,
    output logic              flush,
    output logic [31:0]       branch_target
);

    logic [31:0] fwd_a;
    logic [31:0] fwd_b;
    logic [31:0] op_b;
    logic [31:0] alu_result;
    logic [31:0] product;
    logic [31:0] ex_result;

    // Younger result in EX/MEM wins over MEM/WB
    function automatic logic [31:0] forward(
        input logic [4:0]     rs,
        input logic [31:0]    reg_val,
        input pipe_pkg::fwd_t near,
        input pipe_pkg::fwd_t far
    );
        if (near.reg_write && near.rd != 5'd0 && near.rd == rs) begin
            return near.data;
        end
        if (far.reg_write && far.rd != 5'd0 && far.rd == rs) begin
            return far.data;
        end
        return reg_val;
    endfunction

    // Load data is not ready here, the stall covers that case
    assign fwd_mem.reg_write = ex_mem.ctrl.reg_write && !ex_mem.ctrl.mem_read;
    assign fwd_mem.rd        = ex_mem.rd;
    assign fwd_mem.data      = ex_mem.alu_result;

    assign fwd_a = forward(id_ex.rs1, id_ex.rs1_val, fwd_mem, fwd_wb);
    assign fwd_b = forward(id_ex.rs2, id_ex.rs2_val, fwd_mem, fwd_wb);
    assign op_b  = id_ex.ctrl.alu_src ? id_ex.imm : fwd_b;

    always_comb begin
        case (id_ex.alu_ctrl)
            isa_pkg::alu_sub: alu_result = fwd_a - op_b;
            isa_pkg::alu_and: alu_result = fwd_a & op_b;
            isa_pkg::alu_or:  alu_result = fwd_a | op_b;
            isa_pkg::alu_slt: alu_result = {31'd0, $signed(fwd_a) < $signed(op_b)};
            default:          alu_result = fwd_a + op_b;
        endcase
    end

    // Low word of the npu product
    assign product   = fwd_a * op_b;
    assign ex_result = id_ex.npu_en ? product : alu_result;

    assign flush         = id_ex.ctrl.branch && alu_result == 32'd0;
    assign branch_target = id_ex.pc + id_ex.imm;

    assign ex_mem_read = id_ex.ctrl.mem_read;
    assign ex_rd       = id_ex.rd;

    always_ff @(posedge clk_50) begin
        if (reset) begin
            ex_mem.ctrl <= '0;
        end else begin
            ex_mem.ctrl <= id_ex.ctrl;
        end
        ex_mem.alu_result <= ex_result;
        ex_mem.store_data <= fwd_b;
        ex_mem.rd         <= id_ex.rd;
    end

endmodule

// File: source/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage #(
    parameter int IMEM_WORDS = 256
) (
    input  logic                          clk_50,
    input  logic                          reset,
    input  logic                          stall,
    input  logic                          flush,
    input  logic [31:0]                   branch_target,
    input  logic                          imem_we,
    input  logic [$clog2(IMEM_WORDS)-1:0] imem_addr,
    input  logic [31:0]                   imem_data,
    output pipe_pkg::if_id_t              if_id
);

    localparam int AW = $clog2(IMEM_WORDS);

    logic [31:0] imem [IMEM_WORDS];
    logic [31:0] pc;

    // Program load only while the core sits in reset
    always_ff @(posedge clk_50) begin
        if (reset && imem_we) begin
            imem[imem_addr] <= imem_data;
        end
    end

    always_ff @(posedge clk_50) begin
        if (reset) begin
            pc <= '0;
        end else if (flush) begin
            pc <= branch_target;
        end else if (!stall) begin
            pc <= pc + 32'd4;
        end
    end

    always_ff @(posedge clk_50) begin
        if (reset || flush) begin
            if_id.valid <= 1'b0;
        end else if (!stall) begin
            if_id.valid <= 1'b1;
            if_id.pc    <= pc;
            if_id.inst  <= imem[pc[AW+1:2]];
        end
    end

endmodule

// File: source/isa_pkg.sv
package isa_pkg;

    // Major opcodes, custom-0 carries the npu instruction
    localparam logic [6:0] op_rtype  = 7'b0110011;
    localparam logic [6:0] op_itype  = 7'b0010011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_npu    = 7'b0001011;

    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    localparam logic [6:0] f7_sub = 7'b0100000;

    typedef enum logic [3:0] {
        alu_add = 4'd0,
        alu_sub = 4'd1,
        alu_and = 4'd2,
        alu_or  = 4'd3,
        alu_slt = 4'd4,
        alu_npu = 4'd8
    } alu_ctrl_t;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
    } inst_u;

endpackage

// File: source/memory_stage.sv
`timescale 1ns/1ps

module memory_stage #(
    parameter int DMEM_WORDS = 256
) (
    input  logic              clk_50,
    input  logic              reset,
    input  pipe_pkg::ex_mem_t ex_mem,
    output pipe_pkg::mem_wb_t mem_wb
);

    localparam int AW = $clog2(DMEM_WORDS);

    logic [31:0]   dmem [DMEM_WORDS];
    logic [AW-1:0] word_addr;
    logic [31:0]   load_data;

    // Word addressed, byte offset dropped
    assign word_addr = ex_mem.alu_result[AW+1:2];
    assign load_data = dmem[word_addr];

    always_ff @(posedge clk_50) begin
        if (ex_mem.ctrl.mem_write) begin
            dmem[word_addr] <= ex_mem.store_data;
        end
    end

    always_ff @(posedge clk_50) begin
        if (reset) begin
            mem_wb.valid <= 1'b0;
        end else begin
            mem_wb.valid <= ex_mem.ctrl.reg_write;
        end
        mem_wb.rd   <= ex_mem.rd;
        mem_wb.data <= ex_mem.ctrl.mem_to_reg ? load_data : ex_mem.alu_result;
    end

endmodule

// File: source/pipe_pkg.sv
package pipe_pkg;

    typedef struct packed {
        logic reg_write;
        logic mem_read;
        logic mem_write;
        logic mem_to_reg;
        logic alu_src;
        logic branch;
    } ctrl_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] inst;
    } if_id_t;

    typedef struct packed {
        ctrl_t               ctrl;
        isa_pkg::alu_ctrl_t  alu_ctrl;
        logic                npu_en;
        logic [31:0]         pc;
        logic [31:0]         rs1_val;
        logic [31:0]         rs2_val;
        logic [31:0]         imm;
        logic [4:0]          rs1;
        logic [4:0]          rs2;
        logic [4:0]          rd;
    } id_ex_t;

    typedef struct packed {
        ctrl_t       ctrl;
        logic [31:0] alu_result;
        logic [31:0] store_data;
        logic [4:0]  rd;
    } ex_mem_t;

    // Also used as the retire record
    typedef struct packed {
        logic        valid;
        logic [4:0]  rd;
        logic [31:0] data;
    } mem_wb_t;

    typedef struct packed {
        logic        reg_write;
        logic [4:0]  rd;
        logic [31:0] data;
    } fwd_t;

endpackage

// File: source/register_file.sv
`timescale 1ns/1ps

module register_file (
    input  logic              clk_50,
    input  logic              reset,
    input  logic [4:0]        rr1,
    input  logic [4:0]        rr2,
    input  pipe_pkg::mem_wb_t wb,
    output logic [31:0]       rd1,
    output logic [31:0]       rd2,
    input  logic [4:0]        dbg_addr,
    output logic [31:0]       dbg_data
);

    logic [31:0] regs [32];

    always_ff @(posedge clk_50) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && wb.rd != 5'd0) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // Writeback data bypasses the array on an address match
    assign rd1 = (rr1 == 5'd0) ? 32'd0 :
                 (wb.valid && wb.rd == rr1) ? wb.data : regs[rr1];
    assign rd2 = (rr2 == 5'd0) ? 32'd0 :
                 (wb.valid && wb.rd == rr2) ? wb.data : regs[rr2];

    assign dbg_data = regs[dbg_addr];

endmodule

// File: source/riscv_core.sv
`timescale 1ns/1ps

module riscv_core #(
    parameter int IMEM_WORDS = 256,
    parameter int DMEM_WORDS = 256
) (
    input  logic                          clk_50,
    input  logic                          reset,
    input  logic                          imem_we,
    input  logic [$clog2(IMEM_WORDS)-1:0] imem_addr,
    input  logic [31:0]                   imem_data,
    input  logic [4:0]                    dbg_addr,
    output logic [31:0]                   dbg_data,
    output pipe_pkg::mem_wb_t             retire
);

    pipe_pkg::if_id_t  if_id;
    pipe_pkg::id_ex_t  id_ex;
    pipe_pkg::ex_mem_t ex_mem;
    pipe_pkg::mem_wb_t mem_wb;
    pipe_pkg::fwd_t    fwd_mem;
    pipe_pkg::fwd_t    fwd_wb;
    logic              stall;
    logic              flush;
    logic [31:0]       branch_target;
    logic              ex_mem_read;
    logic [4:0]        ex_rd;

    // Writeback doubles as the far forwarding bus
    assign fwd_wb.reg_write = mem_wb.valid;
    assign fwd_wb.rd        = mem_wb.rd;
    assign fwd_wb.data      = mem_wb.data;

    assign retire = mem_wb;

    fetch_stage #(.IMEM_WORDS(IMEM_WORDS)) u_fetch (
        .clk_50        (clk_50),
        .reset         (reset),
        .stall         (stall),
        .flush         (flush),
        .branch_target (branch_target),
        .imem_we       (imem_we),
        .imem_addr     (imem_addr),
        .imem_data     (imem_data),
        .if_id         (if_id)
    );

    decode_stage u_decode (
        .clk_50      (clk_50),
        .reset       (reset),
        .if_id       (if_id),
        .wb          (mem_wb),
        .flush       (flush),
        .ex_mem_read (ex_mem_read),
        .ex_rd       (ex_rd),
        .dbg_addr    (dbg_addr),
        .dbg_data    (dbg_data),
        .stall       (stall),
        .id_ex       (id_ex)
    );

    execute_stage u_execute (
        .clk_50        (clk_50),
        .reset         (reset),
        .id_ex         (id_ex),
        .fwd_wb        (fwd_wb),
        .ex_mem        (ex_mem),
        .fwd_mem       (fwd_mem),
        .ex_mem_read   (ex_mem_read),
        .ex_rd         (ex_rd),
        .flush         (flush),
        .branch_target (branch_target)
    );

    memory_stage #(.DMEM_WORDS(DMEM_WORDS)) u_memory (
        .clk_50 (clk_50),
        .reset  (reset),
        .ex_mem (ex_mem),
        .mem_wb (mem_wb)
    );

endmodule

// File: test/core_tb.sv
`timescale 1ns/1ps

module core_tb;

    localparam int imem_words   = 64;
    localparam int dmem_words   = 64;
    localparam int addr_bits    = $clog2(imem_words);
    localparam int dmem_bits    = $clog2(dmem_words);
    localparam int reset_cycles = 5;
    localparam int run_cycles   = 200;
    // Twice the run covers program load, reset and the register sweep
    localparam int cycle_limit  = 2 * run_cycles;
    localparam logic [4:0] marker_a = 5'd20;
    localparam logic [4:0] marker_b = 5'd21;

    logic                 clk_50;
    logic                 reset;
    logic                 imem_we;
    logic [addr_bits-1:0] imem_addr;
    logic [31:0]          imem_data;
    logic [4:0]           dbg_addr;
    logic [31:0]          dbg_data;
    pipe_pkg::mem_wb_t    retire;

    integer            seed;
    int                cycle_count = 0;
    int                prog_len;
    logic [31:0]       prog [imem_words];
    logic [31:0]       model_regs [32];
    logic [31:0]       model_mem [dmem_words];
    pipe_pkg::mem_wb_t exp_queue [$];
    pipe_pkg::mem_wb_t expected;

    riscv_core #(
        .IMEM_WORDS (imem_words),
        .DMEM_WORDS (dmem_words)
    ) u_riscv_core (
        .clk_50    (clk_50),
        .reset     (reset),
        .imem_we   (imem_we),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .dbg_addr  (dbg_addr),
        .dbg_data  (dbg_data),
        .retire    (retire)
    );

    initial begin
        clk_50 = 1'b0;
        forever #2 clk_50 = ~clk_50;
    end

    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    // Encodes sw with funct3 010
    function automatic logic [31:0] s_word(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], isa_pkg::op_store};
    endfunction

    function automatic logic [31:0] b_word(input logic [12:0] off, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], isa_pkg::op_branch};
    endfunction

    function automatic logic [11:0] random_imm();
        logic [31:0] r;
        r = $random(seed);
        return r[11:0];
    endfunction

    task automatic append(input logic [31:0] word);
        prog[addr_bits'(prog_len)] = word;
        prog_len++;
    endtask

    task automatic build_program();
        logic [11:0] imm_a;
        logic [11:0] imm_b;
        imm_a = random_imm();
        imm_b = random_imm();
        // Negative x1 and x2 give slt a signed compare
        // x2 must differ from x1 so the first beq falls through
        imm_a[11] = 1'b1;
        imm_b[11] = 1'b1;
        prog_len = 0;
        // Back to back dependent chain
        append(i_word(imm_a, isa_pkg::f3_add_sub, 5'd1, 5'd0, isa_pkg::op_itype));
        append(i_word(imm_b, isa_pkg::f3_add_sub, 5'd2, 5'd1, isa_pkg::op_itype));
        append(r_word(7'd0, isa_pkg::f3_add_sub, 5'd3, 5'd1, 5'd2, isa_pkg::op_rtype));
        append(r_word(isa_pkg::f7_sub, isa_pkg::f3_add_sub, 5'd4, 5'd3, 5'd1,
                      isa_pkg::op_rtype));
        append(r_word(7'd0, isa_pkg::f3_and, 5'd5, 5'd4, 5'd3, isa_pkg::op_rtype));
        append(r_word(7'd0, isa_pkg::f3_or, 5'd6, 5'd5, 5'd2, isa_pkg::op_rtype));
        append(r_word(7'd0, isa_pkg::f3_slt, 5'd7, 5'd6, 5'd0, isa_pkg::op_rtype));
        // Positive immediate keeps x8 nonzero for the load check
        append(i_word(random_imm() & 12'h7ff, isa_pkg::f3_add_sub, 5'd8, 5'd7,
                      isa_pkg::op_itype));
        // Store a forwarded value and reload it for immediate use
        append(s_word(12'd16, 5'd0, 5'd8));
        append(i_word(12'd16, 3'b010, 5'd9, 5'd0, isa_pkg::op_load));
        append(r_word(7'd0, isa_pkg::f3_add_sub, 5'd10, 5'd9, 5'd1, isa_pkg::op_rtype));
        append(r_word(7'd0, 3'b000, 5'd11, 5'd3, 5'd4, isa_pkg::op_npu));
        // Nonzero immediate so a write into x0 would show
        append(i_word(random_imm() | 12'h001, isa_pkg::f3_add_sub, 5'd0, 5'd0,
                      isa_pkg::op_itype));
        append(r_word(7'd0, isa_pkg::f3_add_sub, 5'd12, 5'd0, 5'd11, isa_pkg::op_rtype));
        // A not taken beq followed by a taken one over the two markers
        append(b_word(13'd8, 5'd1, 5'd2));
        append(i_word(12'd5, isa_pkg::f3_add_sub, 5'd13, 5'd1, isa_pkg::op_itype));
        append(b_word(13'd12, 5'd3, 5'd3));
        append(i_word(12'd1, isa_pkg::f3_add_sub, marker_a, 5'd0, isa_pkg::op_itype));
        append(i_word(12'd2, isa_pkg::f3_add_sub, marker_b, 5'd0, isa_pkg::op_itype));
        append(i_word(random_imm(), isa_pkg::f3_add_sub, 5'd14, 5'd13, isa_pkg::op_itype));
        append(b_word(13'd0, 5'd0, 5'd0));
    endtask

    // Instruction level model that queues one record per register write
    task automatic run_model();
        logic [31:0]       pc;
        logic [31:0]       pc_next;
        logic [31:0]       w;
        logic [31:0]       a;
        logic [31:0]       b;
        logic [31:0]       res;
        logic [31:0]       addr;
        logic [31:0]       imm_b;
        logic              writes;
        logic              done;
        int                steps;
        pipe_pkg::mem_wb_t rec;
        pc    = '0;
        done  = 1'b0;
        steps = 0;
        for (int r = 0; r < 32; r++) begin
            model_regs[5'(r)] = '0;
        end
        while (!done && steps < imem_words) begin
            w       = prog[pc[addr_bits+1:2]];
            a       = model_regs[w[19:15]];
            b       = model_regs[w[24:20]];
            imm_b   = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            writes  = 1'b1;
            res     = '0;
            pc_next = pc + 32'd4;
            case (w[6:0])
                isa_pkg::op_rtype: begin
                    case (w[14:12])
                        3'b000:  res = (w[31:25] == 7'b0100000) ? a - b : a + b;
                        3'b010:  res = {31'd0, $signed(a) < $signed(b)};
                        3'b110:  res = a | b;
                        default: res = a & b;
                    endcase
                end
                isa_pkg::op_itype: res = a + {{20{w[31]}}, w[31:20]};
                isa_pkg::op_npu:   res = a * b;
                isa_pkg::op_load: begin
                    addr = a + {{20{w[31]}}, w[31:20]};
                    res  = model_mem[addr[dmem_bits+1:2]];
                end
                isa_pkg::op_store: begin
                    writes = 1'b0;
                    addr   = a + {{20{w[31]}}, w[31:25], w[11:7]};
                    model_mem[addr[dmem_bits+1:2]] = b;
                end
                default: begin
                    writes = 1'b0;
                    if (a == b) begin
                        // Taken branch onto itself ends the program
                        done    = (imm_b == 32'd0);
                        pc_next = pc + imm_b;
                    end
                end
            endcase
            if (writes) begin
                rec.valid = 1'b1;
                rec.rd    = w[11:7];
                rec.data  = res;
                exp_queue.push_back(rec);
                if (w[11:7] != 5'd0) begin
                    model_regs[w[11:7]] = res;
                end
            end
            pc = pc_next;
            steps++;
        end
    endtask

    always @(negedge clk_50) begin
        if (retire.valid) begin
            assert (retire.rd != marker_a && retire.rd != marker_b) else begin
                $display("Fail retire.rd got %h from behind a taken branch", retire.rd);
                $display("Some tests failed");
                $fatal(1);
            end
            assert (exp_queue.size() != 0) else begin
                $display("A retire record came after the last expected register write");
                $display("Some tests failed");
                $fatal(1);
            end
            expected = exp_queue.pop_front();
            assert (retire.rd == expected.rd) else begin
                $display("Fail retire.rd got %h expected %h", retire.rd, expected.rd);
                $display("Some tests failed");
                $fatal(1);
            end
            assert (retire.data == expected.data) else begin
                $display("Fail retire.data got %h expected %h", retire.data, expected.data);
                $display("Some tests failed");
                $fatal(1);
            end
        end
    end

    always @(posedge clk_50) begin
        if (!reset && dbg_addr == 5'd0) begin
            assert (dbg_data == 32'd0) else begin
                $display("Fail dbg_data for x0 got %h expected %h", dbg_data, 32'd0);
                $display("Some tests failed");
                $fatal(1);
            end
        end
    end

    always @(posedge clk_50) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("The run did not finish within %0d cycles", cycle_limit);
            $display("Some tests failed");
            $fatal(1);
        end
    end

    initial begin
        seed      = 32'h0cf6_d945;
        reset     = 1'b1;
        imem_we   = 1'b0;
        imem_addr = '0;
        imem_data = '0;
        dbg_addr  = 5'd0;
        build_program();
        run_model();
        // Program goes in while reset holds the core
        for (int i = 0; i < prog_len; i++) begin
            @(negedge clk_50);
            imem_we   = 1'b1;
            imem_addr = addr_bits'(i);
            imem_data = prog[addr_bits'(i)];
        end
        @(negedge clk_50);
        imem_we = 1'b0;
        repeat (reset_cycles - 1) @(negedge clk_50);
        reset = 1'b0;
        repeat (run_cycles) @(negedge clk_50);
        @(posedge clk_50);
        assert (exp_queue.size() == 0) else begin
            $display("%0d expected register writes never retired", exp_queue.size());
            $display("Some tests failed");
            $fatal(1);
        end
        for (int r = 0; r < 32; r++) begin
            @(negedge clk_50);
            dbg_addr = 5'(r);
            @(posedge clk_50);
            assert (dbg_data == model_regs[5'(r)]) else begin
                $display("Fail dbg_data for x%0d got %h expected %h",
                         r, dbg_data, model_regs[5'(r)]);
                $display("Some tests failed");
                $fatal(1);
            end
        end
        $display("All tests passed");
        $finish;
    end

endmodule
